/* Bender.yml */
package:
  name: valu

sources:
  - source/valu_pkg.sv
  - source/valu_add_lanes.sv
  - source/valu_shift_lanes.sv
  - source/valu_minmax_lanes.sv
  - source/valu_mul_lanes.sv
  - source/valu_result_mux.sv
  - source/valu_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/valu_tb.sv

/* dv/valu_model.svh */
`ifndef VALU_MODEL_SVH
`define VALU_MODEL_SVH

// Lane width in bits for an element width
function automatic int lane_width(sew_e sew);
    case (sew)
        EW8:     return 8;
        EW16:    return 16;
        default: return 32;
    endcase
endfunction

function automatic bit is_mul_op(valu_op_e op);
    return op inside {vmul, vmulh, vmulhu, vmulhsu};
endfunction

// Sign extension of a w-bit lane value
function automatic longint sext(longint unsigned v, int w);
    return longint'(v << (64 - w)) >>> (64 - w);
endfunction

// Expected result of one instruction, computed lane by lane
function automatic vreg_t model_result(vreg_t a, vreg_t b, valu_op_e op, sew_e sew);
    int              w;
    int              sh;
    longint unsigned x, y, r, mask;
    longint          sx, sy;
    vreg_t           res;
    w    = lane_width(sew);
    mask = (64'd1 << w) - 1;
    res  = '0;
    for (int i = 0; i < VLEN / w; i++) begin
        x  = (a >> (i * w)) & mask;
        y  = (b >> (i * w)) & mask;
        sx = sext(x, w);
        sy = sext(y, w);
        // Only the low log2(w) bits of the b lane count
        sh = int'(y & longint'(w - 1));
        case (op)
            vsub:    r = x - y;
            vrsub:   r = y - x;
            vand:    r = x & y;
            vor:     r = x | y;
            vxor:    r = x ^ y;
            vsll:    r = x << sh;
            vsrl:    r = x >> sh;
            vsra:    r = sx >>> sh;
            vmin:    r = (sx < sy) ? x : y;
            vminu:   r = (x < y) ? x : y;
            vmax:    r = (sx > sy) ? x : y;
            vmaxu:   r = (x > y) ? x : y;
            vmul:    r = x * y;
            vmulh:   r = (sx * sy) >>> w;
            vmulhu:  r = (x * y) >> w;
            vmulhsu: r = (sx * longint'(y)) >>> w;
            default: r = x + y;
        endcase
        res = res | vreg_t'((r & mask) << (i * w));
    end
    return res;
endfunction

`endif

/* dv/valu_tb.sv */
`timescale 1ns/1ps

module valu_tb
    import valu_pkg::*;
;

    localparam int          PERIOD     = 100;
    localparam int          RESET_CYC  = 5;
    localparam int unsigned SEED       = 32'h0f17491d;
    localparam int          N_DIRECTED = 51;
    localparam int          N_TESTS    = N_DIRECTED + 600;

    `include "valu_model.svh"

    // Expected result and whether the DUT result is specified
    typedef struct packed {
        vreg_t value;
        logic  known;
    } expect_t;

    logic           clk;
    logic           reset_n;
    valu_operands_t ops;
    valu_op_e       op;
    sew_e           sew;
    logic           exec;
    vreg_t          result;
    logic           hold;

    expect_t        exp_q[$];
    expect_t        last_exp;
    logic           hold_prev;
    logic           hold_seen;
    int             n_checks;
    int             n_result_err;
    int             n_hold_err;

    valu_top valu_top_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .ops_i    (ops),
        .op_i     (op),
        .sew_i    (sew),
        .exec_i   (exec),
        .result_o (result),
        .hold_o   (hold)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_result(vreg_t got, vreg_t exp);
        n_checks++;
        if (got !== exp) begin
            n_result_err++;
            $display("mismatch result_o: got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_hold(logic got, logic exp);
        n_checks++;
        if (got !== exp) begin
            n_hold_err++;
            $display("mismatch hold_o: got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    // All-ones a against b lanes of value one
    task automatic load_directed(int idx);
        ops.a <= '1;
        op    <= valu_op_e'(idx % 17);
        sew   <= sew_e'(idx / 17);
        exec  <= 1'b1;
        case (idx / 17)
            0:       ops.b <= 64'h0101_0101_0101_0101;
            1:       ops.b <= 64'h0001_0001_0001_0001;
            default: ops.b <= 64'h0000_0001_0000_0001;
        endcase
    endtask

    task automatic load_random();
        ops.a <= {$urandom, $urandom};
        ops.b <= {$urandom, $urandom};
        op    <= valu_op_e'($urandom_range(0, 16));
        sew   <= sew_e'($urandom_range(0, 2));
        exec  <= ($urandom_range(0, 3) != 0);
    endtask

    ////////////////////
    // Checker
    ////////////////////

    // Samples at the falling edge where inputs and outputs are settled
    always @(negedge clk) begin
        expect_t exp_now;
        logic    hold_exp;
        if (reset_n) begin
            if (exp_q.size() > 0) begin
                exp_now = exp_q.pop_front();
                if (exp_now.known) begin
                    check_result(result, exp_now.value);
                end
            end
            hold_exp = exec && is_mul_op(op) && (sew == EW32) && !hold_prev;
            check_hold(hold, hold_exp);
            if (!hold_exp) begin
                // EW32 multiply without exec serves stale product registers
                last_exp.known = !(is_mul_op(op) && (sew == EW32) && !exec);
                last_exp.value = model_result(ops.a, ops.b, op, sew);
            end
            exp_q.push_back(last_exp);
            hold_prev = hold_exp;
            hold_seen = hold;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        ops            = '0;
        op             = vadd;
        sew            = EW8;
        exec           = 1'b0;
        reset_n        = 1'b0;
        hold_prev      = 1'b0;
        hold_seen      = 1'b0;
        last_exp.value = '0;
        last_exp.known = 1'b1;
        n_checks       = 0;
        n_result_err   = 0;
        n_hold_err     = 0;
        void'($urandom(SEED));

        repeat (RESET_CYC - 1) @(posedge clk);
        @(negedge clk);
        check_result(result, '0);
        check_hold(hold, 1'b0);
        @(posedge clk);
        reset_n <= 1'b1;

        for (int n = 0; n < N_TESTS; ) begin
            @(posedge clk);
            // Inputs stay frozen while the DUT holds
            if (!hold_seen) begin
                if (n < N_DIRECTED) begin
                    load_directed(n);
                end else begin
                    load_random();
                end
                n++;
            end
        end
        repeat (3) @(posedge clk);

        $display("checks %0d, result mismatches %0d, hold mismatches %0d",
                 n_checks, n_result_err, n_hold_err);
        if (n_result_err == 0 && n_hold_err == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog allows at most 3 cycles per test
    initial begin
        #((N_TESTS * 3 + RESET_CYC) * PERIOD);
        $display("timeout: test sequence did not complete in time");
        $display("checks %0d, result mismatches %0d, hold mismatches %0d",
                 n_checks, n_result_err, n_hold_err);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* files.f */
+incdir+dv
source/valu_pkg.sv
source/valu_add_lanes.sv
source/valu_shift_lanes.sv
source/valu_minmax_lanes.sv
source/valu_mul_lanes.sv
source/valu_result_mux.sv
source/valu_top.sv
dv/valu_tb.sv

/* source/valu_add_lanes.sv */
`timescale 1ns/1ps

module valu_add_lanes
    import valu_pkg::*;
(
    input  valu_operands_t ops_i,
    input  valu_op_e       op_i,
    input  sew_e           sew_i,
    output vreg_t          sum_o
);

    logic  is_sub;
    vreg_t sub_src, sub_inv;
    vreg_t neg8, neg16, neg32;
    vreg_t addend_a, addend_b8, addend_b16, addend_b32;
    vreg_t sum8, sum16, sum32;

    // vrsub swaps the roles of a and b
    assign is_sub   = op_i inside {vsub, vrsub};
    assign sub_src  = (op_i == vrsub) ? ops_i.a : ops_i.b;
    assign sub_inv  = ~sub_src;
    assign addend_a = (op_i == vrsub) ? ops_i.b : ops_i.a;

    // Two's complement negation, per lane so no carry leaks across
    always_comb begin
        for (int i = 0; i < LANES8; i++) begin
            neg8[8*i +: 8] = sub_inv[8*i +: 8] + 8'd1;
        end
        for (int i = 0; i < LANES16; i++) begin
            neg16[16*i +: 16] = sub_inv[16*i +: 16] + 16'd1;
        end
        for (int i = 0; i < LANES32; i++) begin
            neg32[32*i +: 32] = sub_inv[32*i +: 32] + 32'd1;
        end
    end

    assign addend_b8  = is_sub ? neg8  : ops_i.b;
    assign addend_b16 = is_sub ? neg16 : ops_i.b;
    assign addend_b32 = is_sub ? neg32 : ops_i.b;

    always_comb begin
        for (int i = 0; i < LANES8; i++) begin
            sum8[8*i +: 8] = addend_a[8*i +: 8] + addend_b8[8*i +: 8];
        end
        for (int i = 0; i < LANES16; i++) begin
            sum16[16*i +: 16] = addend_a[16*i +: 16] + addend_b16[16*i +: 16];
        end
        for (int i = 0; i < LANES32; i++) begin
            sum32[32*i +: 32] = addend_a[32*i +: 32] + addend_b32[32*i +: 32];
        end
    end

    always_comb begin
        case (sew_i)
            EW8:     sum_o = sum8;
            EW16:    sum_o = sum16;
            default: sum_o = sum32;
        endcase
    end

endmodule

/* source/valu_minmax_lanes.sv */
`timescale 1ns/1ps

module valu_minmax_lanes
    import valu_pkg::*;
(
    input  valu_operands_t ops_i,
    input  sew_e           sew_i,
    output vreg_t          min_o,
    output vreg_t          minu_o,
    output vreg_t          max_o,
    output vreg_t          maxu_o
);

    vreg_t va, vb;

    assign va = ops_i.a;
    assign vb = ops_i.b;

    // a greater than b picks b for min and a for max
    always_comb begin
        case (sew_i)
            EW8: begin
                for (int i = 0; i < LANES8; i++) begin
                    if ($signed(va[8*i +: 8]) > $signed(vb[8*i +: 8])) begin
                        min_o[8*i +: 8] = vb[8*i +: 8];
                        max_o[8*i +: 8] = va[8*i +: 8];
                    end else begin
                        min_o[8*i +: 8] = va[8*i +: 8];
                        max_o[8*i +: 8] = vb[8*i +: 8];
                    end
                    if (va[8*i +: 8] > vb[8*i +: 8]) begin
                        minu_o[8*i +: 8] = vb[8*i +: 8];
                        maxu_o[8*i +: 8] = va[8*i +: 8];
                    end else begin
                        minu_o[8*i +: 8] = va[8*i +: 8];
                        maxu_o[8*i +: 8] = vb[8*i +: 8];
                    end
                end
            end
            EW16: begin
                for (int i = 0; i < LANES16; i++) begin
                    if ($signed(va[16*i +: 16]) > $signed(vb[16*i +: 16])) begin
                        min_o[16*i +: 16] = vb[16*i +: 16];
                        max_o[16*i +: 16] = va[16*i +: 16];
                    end else begin
                        min_o[16*i +: 16] = va[16*i +: 16];
                        max_o[16*i +: 16] = vb[16*i +: 16];
                    end
                    if (va[16*i +: 16] > vb[16*i +: 16]) begin
                        minu_o[16*i +: 16] = vb[16*i +: 16];
                        maxu_o[16*i +: 16] = va[16*i +: 16];
                    end else begin
                        minu_o[16*i +: 16] = va[16*i +: 16];
                        maxu_o[16*i +: 16] = vb[16*i +: 16];
                    end
                end
            end
            default: begin
                for (int i = 0; i < LANES32; i++) begin
                    if ($signed(va[32*i +: 32]) > $signed(vb[32*i +: 32])) begin
                        min_o[32*i +: 32] = vb[32*i +: 32];
                        max_o[32*i +: 32] = va[32*i +: 32];
                    end else begin
                        min_o[32*i +: 32] = va[32*i +: 32];
                        max_o[32*i +: 32] = vb[32*i +: 32];
                    end
                    if (va[32*i +: 32] > vb[32*i +: 32]) begin
                        minu_o[32*i +: 32] = vb[32*i +: 32];
                        maxu_o[32*i +: 32] = va[32*i +: 32];
                    end else begin
                        minu_o[32*i +: 32] = va[32*i +: 32];
                        maxu_o[32*i +: 32] = vb[32*i +: 32];
                    end
                end
            end
        endcase
    end

endmodule

/* source/valu_mul_lanes.sv */
`timescale 1ns/1ps

module valu_mul_lanes
    import valu_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    input  valu_operands_t ops_i,
    input  valu_op_e       op_i,
    input  sew_e           sew_i,
    input  logic           exec_i,
    output logic           hold_o,
    output vreg_t          product_o
);

    logic        sign_a, sign_b;
    logic        is_mul, mul_low;
    logic        done_q;
    logic [15:0] prod8 [LANES8];
    logic [31:0] prod16 [LANES16];
    vprod_t      prod32 [LANES32];
    vprod_t      prod32_q [LANES32];

    // vmulh signs both operands, vmulhsu only a
    always_comb begin
        case (op_i)
            vmulh:   {sign_a, sign_b} = 2'b11;
            vmulhsu: {sign_a, sign_b} = 2'b10;
            default: {sign_a, sign_b} = 2'b00;
        endcase
    end

    assign is_mul  = op_i inside {vmul, vmulh, vmulhu, vmulhsu};
    assign mul_low = (op_i == vmul);

    ////////////////////
    // Lane multipliers
    ////////////////////

    // One extra bit per operand turns every mode into a signed multiply
    for (genvar i = 0; i < LANES8; i++) begin : g_mul8
        logic signed [8:0]  la, lb;
        logic signed [17:0] p;
        assign la = {sign_a & ops_i.a[8*i+7], ops_i.a[8*i +: 8]};
        assign lb = {sign_b & ops_i.b[8*i+7], ops_i.b[8*i +: 8]};
        assign p  = la * lb;
        assign prod8[i] = p[15:0];
    end

    for (genvar i = 0; i < LANES16; i++) begin : g_mul16
        logic signed [16:0] la, lb;
        logic signed [33:0] p;
        assign la = {sign_a & ops_i.a[16*i+15], ops_i.a[16*i +: 16]};
        assign lb = {sign_b & ops_i.b[16*i+15], ops_i.b[16*i +: 16]};
        assign p  = la * lb;
        assign prod16[i] = p[31:0];
    end

    for (genvar i = 0; i < LANES32; i++) begin : g_mul32
        logic signed [32:0] la, lb;
        logic signed [65:0] p;
        assign la = {sign_a & ops_i.a[32*i+31], ops_i.a[32*i +: 32]};
        assign lb = {sign_b & ops_i.b[32*i+31], ops_i.b[32*i +: 32]};
        assign p  = la * lb;
        assign prod32[i] = p[63:0];
    end

    ////////////////////
    // 32-bit hold
    ////////////////////

    // First EW32 multiply cycle holds and the next one is served from the registers
    assign hold_o = exec_i & is_mul & (sew_i == EW32) & ~done_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= hold_o;
        end
    end

    always_ff @(posedge clk) begin
        if (hold_o) begin
            prod32_q <= prod32;
        end
    end

    always_comb begin
        case (sew_i)
            EW8: begin
                for (int i = 0; i < LANES8; i++) begin
                    product_o[8*i +: 8] = mul_low ? prod8[i][7:0] : prod8[i][15:8];
                end
            end
            EW16: begin
                for (int i = 0; i < LANES16; i++) begin
                    product_o[16*i +: 16] = mul_low ? prod16[i][15:0] : prod16[i][31:16];
                end
            end
            default: begin
                for (int i = 0; i < LANES32; i++) begin
                    product_o[32*i +: 32] = mul_low ? prod32_q[i][31:0] : prod32_q[i][63:32];
                end
            end
        endcase
    end

    // Registered product is only valid if the instruction stays put
    a_hold_inputs_stable: assert property (
        @(posedge clk) disable iff (!reset_n)
        hold_o |=> $stable(ops_i) && $stable(op_i) && $stable(sew_i) && $stable(exec_i)
    );

    a_sew_legal: assert property (
        @(posedge clk) disable iff (!reset_n) exec_i |-> sew_i inside {EW8, EW16, EW32}
    );

endmodule

/* source/valu_pkg.sv */
package valu_pkg;

    ////////////////////
    // Widths
    ////////////////////

    // Vector slice held by one register
    localparam int VLEN = 64;

    // Lane counts per element width
    localparam int LANES8  = VLEN / 8;
    localparam int LANES16 = VLEN / 16;
    localparam int LANES32 = VLEN / 32;

    typedef logic [VLEN-1:0] vreg_t;

    // Full product of one 32-bit lane
    typedef logic [63:0] vprod_t;

    ////////////////////
    // Encodings
    ////////////////////

    // Encoding 2'b11 is unused
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } sew_e;

    typedef enum logic [4:0] {
        vadd, vsub, vrsub,
        vand, vor, vxor,
        vsll, vsrl, vsra,
        vmin, vminu, vmax, vmaxu,
        vmul, vmulh, vmulhu, vmulhsu
    } valu_op_e;

    // Both source operands of one instruction
    typedef struct packed {
        vreg_t a;
        vreg_t b;
    } valu_operands_t;

endpackage

/* source/valu_result_mux.sv */
`timescale 1ns/1ps

module valu_result_mux
    import valu_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    input  valu_operands_t ops_i,
    input  valu_op_e       op_i,
    input  logic           hold_i,
    input  vreg_t          sum_i,
    input  vreg_t          sll_i,
    input  vreg_t          srl_i,
    input  vreg_t          sra_i,
    input  vreg_t          min_i,
    input  vreg_t          minu_i,
    input  vreg_t          max_i,
    input  vreg_t          maxu_i,
    input  vreg_t          product_i,
    output vreg_t          result_o
);

    vreg_t res_and, res_or, res_xor;
    vreg_t res_sel;

    // Bitwise ops need no lane split
    assign res_and = ops_i.a & ops_i.b;
    assign res_or  = ops_i.a | ops_i.b;
    assign res_xor = ops_i.a ^ ops_i.b;

    always_comb begin
        case (op_i)
            vand:    res_sel = res_and;
            vor:     res_sel = res_or;
            vxor:    res_sel = res_xor;
            vsll:    res_sel = sll_i;
            vsrl:    res_sel = srl_i;
            vsra:    res_sel = sra_i;
            vmin:    res_sel = min_i;
            vminu:   res_sel = minu_i;
            vmax:    res_sel = max_i;
            vmaxu:   res_sel = maxu_i;
            vmul, vmulh,
            vmulhu, vmulhsu:
                     res_sel = product_i;
            default: res_sel = sum_i;
        endcase
    end

    // Result freezes through a hold cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o <= '0;
        end else if (!hold_i) begin
            result_o <= res_sel;
        end
    end

    a_op_legal: assert property (
        @(posedge clk) disable iff (!reset_n)
        !hold_i |-> op_i inside {vadd, vsub, vrsub, vand, vor, vxor, vsll, vsrl, vsra,
                                 vmin, vminu, vmax, vmaxu, vmul, vmulh, vmulhu, vmulhsu}
    );

endmodule

/* source/valu_shift_lanes.sv */
`timescale 1ns/1ps

module valu_shift_lanes
    import valu_pkg::*;
(
    input  valu_operands_t ops_i,
    input  sew_e           sew_i,
    output vreg_t          sll_o,
    output vreg_t          srl_o,
    output vreg_t          sra_o
);

    vreg_t va, vb;

    assign va = ops_i.a;
    assign vb = ops_i.b;

    // Shift amount is the low log2(width) bits of each b lane
    always_comb begin
        case (sew_i)
            EW8: begin
                for (int i = 0; i < LANES8; i++) begin
                    sll_o[8*i +: 8] = va[8*i +: 8] << vb[8*i +: 3];
                    srl_o[8*i +: 8] = va[8*i +: 8] >> vb[8*i +: 3];
                    sra_o[8*i +: 8] = $signed(va[8*i +: 8]) >>> vb[8*i +: 3];
                end
            end
            EW16: begin
                for (int i = 0; i < LANES16; i++) begin
                    sll_o[16*i +: 16] = va[16*i +: 16] << vb[16*i +: 4];
                    srl_o[16*i +: 16] = va[16*i +: 16] >> vb[16*i +: 4];
                    sra_o[16*i +: 16] = $signed(va[16*i +: 16]) >>> vb[16*i +: 4];
                end
            end
            default: begin
                for (int i = 0; i < LANES32; i++) begin
                    sll_o[32*i +: 32] = va[32*i +: 32] << vb[32*i +: 5];
                    srl_o[32*i +: 32] = va[32*i +: 32] >> vb[32*i +: 5];
                    // Sign fill from the lane MSB
                    sra_o[32*i +: 32] = $signed(va[32*i +: 32]) >>> vb[32*i +: 5];
                end
            end
        endcase
    end

endmodule

/* source/valu_top.sv */
`timescale 1ns/1ps

module valu_top
    import valu_pkg::*;
(
    input  logic           clk,
    input  logic           reset_n,
    input  valu_operands_t ops_i,
    input  valu_op_e       op_i,
    input  sew_e           sew_i,
    input  logic           exec_i,
    output vreg_t          result_o,
    output logic           hold_o
);

    vreg_t sum, sll, srl, sra;
    vreg_t min, minu, max, maxu;
    vreg_t product;

    ////////////////////
    // Arithmetic units
    ////////////////////

    valu_add_lanes add_i (
        .ops_i (ops_i),
        .op_i  (op_i),
        .sew_i (sew_i),
        .sum_o (sum)
    );

    valu_shift_lanes shift_i (
        .ops_i (ops_i),
        .sew_i (sew_i),
        .sll_o (sll),
        .srl_o (srl),
        .sra_o (sra)
    );

    valu_minmax_lanes minmax_i (
        .ops_i  (ops_i),
        .sew_i  (sew_i),
        .min_o  (min),
        .minu_o (minu),
        .max_o  (max),
        .maxu_o (maxu)
    );

    // Only unit with state, source of the hold
    valu_mul_lanes mul_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .ops_i     (ops_i),
        .op_i      (op_i),
        .sew_i     (sew_i),
        .exec_i    (exec_i),
        .hold_o    (hold_o),
        .product_o (product)
    );

    valu_result_mux result_mux_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .ops_i     (ops_i),
        .op_i      (op_i),
        .hold_i    (hold_o),
        .sum_i     (sum),
        .sll_i     (sll),
        .srl_i     (srl),
        .sra_i     (sra),
        .min_i     (min),
        .minu_i    (minu),
        .max_i     (max),
        .maxu_i    (maxu),
        .product_i (product),
        .result_o  (result_o)
    );

endmodule
